/* soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int unsigned ADR_W = 32;
    localparam int unsigned DAT_W = 8;

    // upper address bits that pick a peripheral page
    localparam int unsigned PAGE_W = 24;

    localparam logic [PAGE_W-1:0] TIMER_PAGE = 24'hFFFFFD;
    localparam logic [PAGE_W-1:0] PRNG_PAGE  = 24'hFFFFFE;
    localparam logic [PAGE_W-1:0] LEDS_PAGE  = 24'hFFFFFF;

    // block ram that everything outside the pages aliases into
    localparam int unsigned RAM_ADDR_BITS = 13;
    localparam int unsigned RAM_DEPTH     = 2 ** RAM_ADDR_BITS;

    // register offset inside a page
    localparam int unsigned REG_ADR_W = 2;

    // timer
    localparam int unsigned TIMER_PRESCALE = 4;
    localparam int unsigned TIMER_PS_W     = $clog2(TIMER_PRESCALE);

    localparam logic [REG_ADR_W-1:0] TMR_RELOAD = 2'd0;
    localparam logic [REG_ADR_W-1:0] TMR_CTRL   = 2'd1;
    localparam logic [REG_ADR_W-1:0] TMR_STATUS = 2'd2;
    localparam logic [REG_ADR_W-1:0] TMR_COUNT  = 2'd3;

    // galois lfsr
    localparam int unsigned PRNG_W = 16;

    localparam logic [PRNG_W-1:0] PRNG_TAPS         = 16'hB400;
    localparam logic [PRNG_W-1:0] PRNG_SEED_DEFAULT = 16'hACE1;

    localparam logic [REG_ADR_W-1:0] PRNG_DATA    = 2'd0;
    localparam logic [REG_ADR_W-1:0] PRNG_SEED_LO = 2'd1;
    localparam logic [REG_ADR_W-1:0] PRNG_SEED_HI = 2'd2;

endpackage

`default_nettype wire

/* bus_decoder.sv */
`default_nettype none

module bus_decoder import soc_pkg::*; (
    input  logic             stb_i,
    input  logic [ADR_W-1:0] adr_i,
    input  logic [DAT_W-1:0] timer_dat_i,
    input  logic             timer_ack_i,
    input  logic [DAT_W-1:0] prng_dat_i,
    input  logic             prng_ack_i,
    input  logic [DAT_W-1:0] leds_dat_i,
    input  logic             leds_ack_i,
    input  logic [DAT_W-1:0] ram_dat_i,
    input  logic             ram_ack_i,
    output logic             timer_stb_o,
    output logic             prng_stb_o,
    output logic             leds_stb_o,
    output logic             ram_stb_o,
    output logic [DAT_W-1:0] dat_o,
    output logic             ack_o
);

    logic [PAGE_W-1:0] page;

    assign page = adr_i[ADR_W-1 -: PAGE_W];

    always_comb begin
        timer_stb_o = 1'b0;
        prng_stb_o  = 1'b0;
        leds_stb_o  = 1'b0;
        ram_stb_o   = 1'b0;

        case (page)
            TIMER_PAGE: begin
                timer_stb_o = stb_i;
                dat_o       = timer_dat_i;
                ack_o       = timer_ack_i;
            end

            PRNG_PAGE: begin
                prng_stb_o = stb_i;
                dat_o      = prng_dat_i;
                ack_o      = prng_ack_i;
            end

            LEDS_PAGE: begin
                leds_stb_o = stb_i;
                dat_o      = leds_dat_i;
                ack_o      = leds_ack_i;
            end

            // anything else lands in ram
            default: begin
                ram_stb_o = stb_i;
                dat_o     = ram_dat_i;
                ack_o     = ram_ack_i;
            end
        endcase
    end

endmodule

`default_nettype wire

/* bram_wb8.sv */
`default_nettype none

module bram_wb8 import soc_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     stb_i,
    input  logic                     we_i,
    input  logic [RAM_ADDR_BITS-1:0] adr_i,
    input  logic [DAT_W-1:0]         dat_i,
    output logic [DAT_W-1:0]         dat_o,
    output logic                     ack_o
);

    logic [DAT_W-1:0] mem [RAM_DEPTH];
    logic             access;

    // new request seen while not yet acknowledged
    assign access = stb_i && !ack_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

endmodule

`default_nettype wire

/* leds_wb8.sv */
`default_nettype none

module leds_wb8 import soc_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  logic [DAT_W-1:0] dat_i,
    output logic [DAT_W-1:0] dat_o,
    output logic             ack_o,
    output logic [DAT_W-1:0] leds_o
);

    logic access;

    assign access = stb_i && !ack_o;

    // any offset in the page hits the same register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o  <= 1'b0;
            leds_o <= '0;
        end else begin
            ack_o <= access;
            if (access && we_i) begin
                leds_o <= dat_i;
            end
        end
    end

    assign dat_o = leds_o;

endmodule

`default_nettype wire

/* timer_wb8.sv */
`default_nettype none

module timer_wb8 import soc_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [REG_ADR_W-1:0] adr_i,
    input  logic [DAT_W-1:0]     dat_i,
    output logic [DAT_W-1:0]     dat_o,
    output logic                 ack_o,
    output logic                 irq_o
);

    logic [TIMER_PS_W-1:0] ps_q;
    logic [DAT_W-1:0]      reload_q;
    logic [DAT_W-1:0]      count_q;
    logic                  enable_q;
    logic                  irq_en_q;
    logic                  status_q;
    logic                  access;
    logic                  wr;
    logic                  tick;
    logic                  wrap;
    logic                  status_clr;

    assign access     = stb_i && !ack_o;
    assign wr         = access && we_i;
    assign tick       = enable_q && (ps_q == TIMER_PS_W'(TIMER_PRESCALE - 1));
    assign wrap       = tick && (count_q == DAT_W'(1));
    assign status_clr = wr && (adr_i == TMR_STATUS) && dat_i[0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o    <= 1'b0;
            ps_q     <= '0;
            reload_q <= '0;
            count_q  <= '0;
            enable_q <= 1'b0;
            irq_en_q <= 1'b0;
            status_q <= 1'b0;
        end else begin
            ack_o <= access;

            // prescaler only runs while enabled
            if (!enable_q || tick) begin
                ps_q <= '0;
            end else begin
                ps_q <= ps_q + 1'b1;
            end

            // a zero count sits idle until a reload is written
            if (wrap) begin
                count_q <= reload_q;
            end else if (tick && count_q > DAT_W'(1)) begin
                count_q <= count_q - 1'b1;
            end

            if (wr && adr_i == TMR_RELOAD) begin
                reload_q <= dat_i;
                count_q  <= dat_i;
            end

            if (wr && adr_i == TMR_CTRL) begin
                enable_q <= dat_i[0];
                irq_en_q <= dat_i[1];
            end

            // a wrap in the same cycle as a clear still counts
            status_q <= wrap || (status_q && !status_clr);
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                TMR_RELOAD: dat_o <= reload_q;
                TMR_CTRL:   dat_o <= {{(DAT_W - 2){1'b0}}, irq_en_q, enable_q};
                TMR_STATUS: dat_o <= {{(DAT_W - 1){1'b0}}, status_q};
                TMR_COUNT:  dat_o <= count_q;
            endcase
        end
    end

    assign irq_o = status_q && irq_en_q;

endmodule

`default_nettype wire

/* prng_wb8.sv */
`default_nettype none

module prng_wb8 import soc_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stb_i,
    input  logic                 we_i,
    input  logic [REG_ADR_W-1:0] adr_i,
    input  logic [DAT_W-1:0]     dat_i,
    output logic [DAT_W-1:0]     dat_o,
    output logic                 ack_o
);

    logic [PRNG_W-1:0] state_q;
    logic [PRNG_W-1:0] step;
    logic [PRNG_W-1:0] seeded;
    logic              access;
    logic              seed_wr;
    logic              data_rd;

    assign access  = stb_i && !ack_o;
    assign seed_wr = access && we_i && (adr_i == PRNG_SEED_LO || adr_i == PRNG_SEED_HI);
    assign data_rd = access && !we_i && (adr_i == PRNG_DATA);

    // one galois step shifts right and folds taps on a shifted-out one
    assign step = {1'b0, state_q[PRNG_W-1:1]} ^ (state_q[0] ? PRNG_TAPS : '0);

    always_comb begin
        seeded = state_q;
        if (adr_i == PRNG_SEED_HI) begin
            seeded[PRNG_W-1:DAT_W] = dat_i;
        end else begin
            seeded[DAT_W-1:0] = dat_i;
        end
        // all-zero state would lock up
        if (seeded == '0) begin
            seeded = PRNG_SEED_DEFAULT;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o   <= 1'b0;
            state_q <= PRNG_SEED_DEFAULT;
        end else begin
            ack_o <= access;
            if (seed_wr) begin
                state_q <= seeded;
            end else if (data_rd) begin
                state_q <= step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_o <= (adr_i == PRNG_SEED_HI) ? state_q[PRNG_W-1:DAT_W] : state_q[DAT_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* soc_top.sv */
`default_nettype none

module soc_top import soc_pkg::*; (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  logic [ADR_W-1:0] adr_i,
    input  logic [DAT_W-1:0] dat_i,
    output logic [DAT_W-1:0] dat_o,
    output logic             ack_o,
    output logic [DAT_W-1:0] leds_o,
    output logic             irq_o
);

    logic             timer_stb;
    logic [DAT_W-1:0] timer_dat;
    logic             timer_ack;

    logic             prng_stb;
    logic [DAT_W-1:0] prng_dat;
    logic             prng_ack;

    logic             leds_stb;
    logic [DAT_W-1:0] leds_dat;
    logic             leds_ack;

    logic             ram_stb;
    logic [DAT_W-1:0] ram_dat;
    logic             ram_ack;

    bus_decoder u_decoder (
        .stb_i       (stb_i),
        .adr_i       (adr_i),
        .timer_dat_i (timer_dat),
        .timer_ack_i (timer_ack),
        .prng_dat_i  (prng_dat),
        .prng_ack_i  (prng_ack),
        .leds_dat_i  (leds_dat),
        .leds_ack_i  (leds_ack),
        .ram_dat_i   (ram_dat),
        .ram_ack_i   (ram_ack),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .leds_stb_o  (leds_stb),
        .ram_stb_o   (ram_stb),
        .dat_o       (dat_o),
        .ack_o       (ack_o)
    );

    // low address bits alias the whole ram
    bram_wb8 u_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (ram_stb),
        .we_i     (we_i),
        .adr_i    (adr_i[RAM_ADDR_BITS-1:0]),
        .dat_i    (dat_i),
        .dat_o    (ram_dat),
        .ack_o    (ram_ack)
    );

    leds_wb8 u_leds (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (leds_stb),
        .we_i     (we_i),
        .dat_i    (dat_i),
        .dat_o    (leds_dat),
        .ack_o    (leds_ack),
        .leds_o   (leds_o)
    );

    timer_wb8 u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (timer_stb),
        .we_i     (we_i),
        .adr_i    (adr_i[REG_ADR_W-1:0]),
        .dat_i    (dat_i),
        .dat_o    (timer_dat),
        .ack_o    (timer_ack),
        .irq_o    (irq_o)
    );

    prng_wb8 u_prng (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (prng_stb),
        .we_i     (we_i),
        .adr_i    (adr_i[REG_ADR_W-1:0]),
        .dat_i    (dat_i),
        .dat_o    (prng_dat),
        .ack_o    (prng_ack)
    );

endmodule

`default_nettype wire

/* soc_checker.sv */
`default_nettype none

module soc_checker import soc_pkg::*; (
    input logic             clk,
    input logic             arst_n_i,
    input logic             stb_i,
    input logic             ack_i,
    input logic [DAT_W-1:0] leds_i,
    input logic             irq_i
);

    int unsigned failures = 0;

    // every ack answers a strobe from the cycle before
    ack_after_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i) ack_i |-> $past(stb_i)
    ) else begin
        failures++;
        $error("ack_o high without stb_i in the previous cycle");
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n_i) ack_i |=> !ack_i
    ) else begin
        failures++;
        $error("ack_o high for two cycles in a row");
    end

    // outputs idle while reset is held
    reset_outputs_low: assert property (
        @(posedge clk) !arst_n_i |-> (leds_i == '0 && !irq_i)
    ) else begin
        failures++;
        $error("leds_o or irq_o not zero during reset");
    end

endmodule

bind soc_top soc_checker u_checker (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stb_i    (stb_i),
    .ack_i    (ack_o),
    .leds_i   (leds_o),
    .irq_i    (irq_o)
);

`default_nettype wire

/* tb_soc.sv */
`default_nettype none

module tb_soc import soc_pkg::*; ();

    logic              clk;
    logic              arst_n;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DAT_W-1:0]  wdat;
    logic [DAT_W-1:0]  rdat;
    logic              ack;
    logic [DAT_W-1:0]  leds;
    logic              irq;
    logic [31:0]       lcg_state;
    logic [PRNG_W-1:0] prng_model;

    soc_top u_dut (
        .clk      (clk),
        .arst_n_i (arst_n),
        .stb_i    (stb),
        .we_i     (we),
        .adr_i    (adr),
        .dat_i    (wdat),
        .dat_o    (rdat),
        .ack_o    (ack),
        .leds_o   (leds),
        .irq_o    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_error($sformatf("MISMATCH at time %0t: %s is 0x%0h, expected 0x%0h",
                                      $time, name, got, expected));
        end
    endtask

    always @(u_dut.u_checker.failures) begin
        if (u_dut.u_checker.failures != 0) begin
            stop_with_error("a bus protocol assertion in soc_checker failed");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference galois step that shifts right and folds the taps on a one
    function automatic logic [PRNG_W-1:0] prng_step(input logic [PRNG_W-1:0] s);
        return (s >> 1) ^ (s[0] ? PRNG_TAPS : 16'h0000);
    endfunction

    // one access where ack must follow the strobe after exactly one cycle
    task automatic bus_access(input logic write, input logic [ADR_W-1:0] addr,
                              input logic [DAT_W-1:0] data, output logic [DAT_W-1:0] result);
        int cycles;
        @(negedge clk);
        check_value("ack_o between accesses", ack, 0);
        stb = 1'b1;
        we = write;
        adr = addr;
        wdat = data;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                stop_with_error($sformatf("no ack_o for the access to 0x%h", addr));
            end
        end while (ack !== 1'b1);
        check_value("ack_o latency", cycles, 1);
        result = rdat;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic bus_write(input logic [ADR_W-1:0] addr, input logic [DAT_W-1:0] data);
        logic [DAT_W-1:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic [ADR_W-1:0] addr, output logic [DAT_W-1:0] data);
        bus_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        while (irq !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > 500) begin
                stop_with_error("timed out waiting for irq_o to change");
            end
        end
    endtask

    task automatic poll_read(input logic [ADR_W-1:0] addr, input logic [DAT_W-1:0] expected);
        logic [DAT_W-1:0] got;
        int tries;
        tries = 0;
        bus_read(addr, got);
        while (got !== expected) begin
            tries++;
            if (tries > 100) begin
                stop_with_error($sformatf("register at 0x%h never reached 0x%h", addr, expected));
            end
            bus_read(addr, got);
        end
    endtask

    // random bytes at random ram addresses read back direct and aliased
    task automatic ram_random_test();
        logic [ADR_W-1:0] addr;
        logic [DAT_W-1:0] data;
        logic [DAT_W-1:0] got;
        logic [DAT_W-1:0] leds_before;
        leds_before = leds;
        for (int i = 0; i < 32; i++) begin
            lcg_state = lcg_next(lcg_state);
            addr = ADR_W'(lcg_state[31:16] % RAM_DEPTH);
            lcg_state = lcg_next(lcg_state);
            data = lcg_state[23:16];
            bus_write(addr, data);
            bus_read(addr, got);
            check_value($sformatf("dat_o at 0x%h", addr), got, data);
            bus_read(addr + RAM_DEPTH, got);
            check_value($sformatf("dat_o at 0x%h", addr + RAM_DEPTH), got, data);
        end
        check_value("leds_o after ram writes", leds, leds_before);
    endtask

    task automatic apply_pattern(input logic [7:0] op, input logic [ADR_W-1:0] addr,
                                 input logic [DAT_W-1:0] data);
        logic [DAT_W-1:0] got;
        case (op)
            "W": begin
                bus_write(addr, data);
                if (addr[ADR_W-1 -: PAGE_W] == PRNG_PAGE && addr[1:0] == 2'd1)
                    prng_model[7:0] = data;
                if (addr[ADR_W-1 -: PAGE_W] == PRNG_PAGE && addr[1:0] == 2'd2)
                    prng_model[15:8] = data;
                if (prng_model == 16'h0000)
                    prng_model = PRNG_SEED_DEFAULT;
            end
            "R": begin
                bus_read(addr, got);
                check_value($sformatf("dat_o at 0x%h", addr), got, data);
            end
            "P": begin
                bus_read(addr, got);
                check_value("prng dat_o", got, prng_model[7:0]);
                prng_model = prng_step(prng_model);
            end
            "L": check_value("leds_o", leds, data);
            "Q": check_value("irq_o", irq, data[0]);
            "I": wait_irq(data[0]);
            "S": poll_read(addr, data);
            default: stop_with_error($sformatf("unknown operation %c in the patterns", op));
        endcase
    endtask

    task automatic run_patterns();
        int fd;
        int n;
        string line;
        logic [7:0] op;
        logic [ADR_W-1:0] addr;
        logic [DAT_W-1:0] data;
        fd = $fopen("soc_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open soc_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%c %h %h", op, addr, data);
            if (n == 3 && op != "#") begin
                apply_pattern(op, addr, data);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        arst_n = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        wdat = '0;
        lcg_state = 32'd5008;
        prng_model = PRNG_SEED_DEFAULT;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        ram_random_test();
        run_patterns();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* soc_patterns.txt */
# op address data in hex: W write, R read and compare, P prng read checked against the model
# L leds_o equals data, Q irq_o equals data, I wait for irq_o, S poll a read until it equals data
P FFFFFE00 00
P FFFFFE00 00
W FFFFFE01 34
W FFFFFE02 12
R FFFFFE01 34
R FFFFFE02 12
P FFFFFE00 00
P FFFFFE00 00
P FFFFFE00 00
P FFFFFE00 00
W FFFFFE01 00
W FFFFFE02 00
R FFFFFE02 AC
R FFFFFE01 E1
P FFFFFE00 00
P FFFFFE00 00
W FFFFFF00 A5
L 00000000 A5
R FFFFFF00 A5
W FFFFFF03 3C
R FFFFFF02 3C
W 00000010 77
L 00000000 3C
R 00002010 77
R 12340010 77
W FFFFFD00 03
R FFFFFD00 03
W FFFFFD01 03
I 00000000 01
R FFFFFD02 01
W FFFFFD02 01
Q 00000000 00
W FFFFFD01 01
W FFFFFD02 01
S FFFFFD02 01
Q 00000000 00
W FFFFFD01 00

/* files.f */
soc_pkg.sv
bus_decoder.sv
bram_wb8.sv
leds_wb8.sv
timer_wb8.sv
prng_wb8.sv
soc_top.sv
soc_checker.sv
tb_soc.sv
